// ==== flist.f ====
+incdir+rtl
rtl/cic_pkg.sv
rtl/cic_integrator_chain.sv
rtl/cic_comb_decimator.sv
rtl/cic_credit_buffer.sv
rtl/cic_decimator_top.sv
verification/tb_cic.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the CIC decimator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_cic

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_cic \
    -Mdir "$OBJ" \
    -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the fail line on any failed check or timeout
if grep -q "Test failed" "$LOG"; then
    echo "simulation FAILED, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

// ==== verification/tb_cic.sv ====
`timescale 1ns/1ps
`include "cic_settings.svh"

module tb_cic;

    localparam int PERIOD    = 4;
    localparam int STAGES    = `CIC_STAGES;
    localparam int R         = `CIC_DECIMATION;
    localparam int D         = `CIC_DIFF_DELAY;
    localparam int CREDITS   = `CIC_CREDITS;
    localparam int BUF_DEPTH = `CIC_BUF_DEPTH;

    // phase lengths in input cycles
    localparam int IDLE_CYC  = 40;
    localparam int IMP_LEN   = 12 * R;
    localparam int DC_LEN    = 12 * R;
    localparam int RAND_CYC  = 400;
    // 20 outputs, well past buffer plus receiver depth
    localparam int STALL_LEN = 20 * R;
    localparam int DRAIN_MAX = 300;
    localparam int N_DRAINS  = 5;
    localparam int QUIET_CYC = 40;
    localparam int STIM_CYC  = IDLE_CYC + IMP_LEN + 2 * DC_LEN + RAND_CYC + STALL_LEN + 8;
    localparam int WATCHDOG_NS = (STIM_CYC + N_DRAINS * DRAIN_MAX + 200) * PERIOD;

    logic          clk_out;
    logic          rst_n;
    cic_pkg::din_t din;
    logic          din_valid;
    cic_pkg::acc_t dout;
    logic          dout_valid;
    logic          credit_return = 1'b0;
    logic          overrun;

    int seed = 86115;
    int rx_seed;

    // reference CIC state
    cic_pkg::acc_t m_acc  [STAGES];
    cic_pkg::acc_t m_hist [STAGES][D];
    int            m_vcount;
    cic_pkg::acc_t exp_q  [$];

    // receiver and monitor state, written only by the monitor
    int            held = 0;
    int            ret_delay = 0;
    int            sent_cnt = 0;
    int            returned_cnt = 0;
    int            cyc = 0;
    int            last_rx_cyc = 0;
    int            out_cnt = 0;
    longint        out_sum = 0;
    cic_pkg::acc_t last_out = '0;
    int            mon_val_errs = 0;
    int            mon_other_errs = 0;
    int            mon_skipped = 0;

    // set by the stimulus process only
    logic          credit_enable = 1'b1;
    logic          skip_mode = 1'b0;
    int            main_val_errs = 0;
    int            main_other_errs = 0;

    cic_decimator_top u_dut (
        .clk_out       (clk_out),
        .rst_n         (rst_n),
        .din           (din),
        .din_valid     (din_valid),
        .dout          (dout),
        .dout_valid    (dout_valid),
        .credit_return (credit_return),
        .overrun       (overrun)
    );

    initial begin
        clk_out = 1'b0;
        forever begin
            #(PERIOD / 2) clk_out = ~clk_out;
        end
    end

    // DC gain of the full-rate filter, (R*D)**N
    function automatic longint dc_gain();
        longint g;
        g = 1;
        for (int k = 0; k < STAGES; k++) begin
            g = g * longint'(R * D);
        end
        return g;
    endfunction

    task automatic model_clear();
        for (int k = 0; k < STAGES; k++) begin
            m_acc[k] = '0;
            for (int j = 0; j < D; j++) begin
                m_hist[k][j] = '0;
            end
        end
        m_vcount = 0;
    endtask

    // one valid input into the reference filter
    task automatic model_step(input cic_pkg::din_t x);
        cic_pkg::acc_t v;
        cic_pkg::acc_t t;
        m_acc[0] = m_acc[0] + cic_pkg::acc_t'(x);
        for (int k = 1; k < STAGES; k++) begin
            m_acc[k] = m_acc[k] + m_acc[k-1];
        end
        m_vcount = m_vcount + 1;
        // every R-th valid since reset goes through the combs
        if (m_vcount % R == 0) begin
            v = m_acc[STAGES-1];
            for (int k = 0; k < STAGES; k++) begin
                t = v - m_hist[k][D-1];
                for (int j = D - 1; j > 0; j--) begin
                    m_hist[k][j] = m_hist[k][j-1];
                end
                m_hist[k][0] = v;
                v = t;
            end
            exp_q.push_back(v);
        end
    endtask

    // compare one received sample against the expected stream
    task automatic score_output(input cic_pkg::acc_t value);
        cic_pkg::acc_t want;
        int            idx;
        sent_cnt    = sent_cnt + 1;
        out_cnt     = out_cnt + 1;
        out_sum     = out_sum + longint'(value);
        last_out    = value;
        last_rx_cyc = cyc;
        if (held >= CREDITS) begin
            mon_other_errs++;
            $display("receiver got a sample at %0t while already holding %0d", $time, held);
        end
        held = held + 1;
        if (exp_q.size() == 0) begin
            mon_other_errs++;
            $display("output 0x%h at %0t with no sample expected", value, $time);
        end else if (!skip_mode) begin
            want = exp_q.pop_front();
            if (want !== value) begin
                mon_val_errs++;
                $display("ERR dout: expected 0x%h actual 0x%h at %0t", want, value, $time);
            end
        end else begin
            // dropped samples leave gaps, so search forward
            idx = 0;
            while (idx < exp_q.size() && exp_q[idx] !== value) begin
                idx++;
            end
            if (idx == exp_q.size()) begin
                mon_other_errs++;
                $display("output 0x%h at %0t matches no pending sample", value, $time);
            end else begin
                repeat (idx) begin
                    want = exp_q.pop_front();
                    mon_skipped++;
                end
                want = exp_q.pop_front();
            end
        end
    endtask

    // monitor plus credit-returning receiver, on the stable half cycle
    always @(negedge clk_out) begin
        cyc = cyc + 1;
        if (dout_valid === 1'b1) begin
            score_output(dout);
        end
        if (sent_cnt > CREDITS + returned_cnt) begin
            mon_other_errs++;
            $display("credit rule broken: %0d sent, only %0d credits returned", sent_cnt,
                     returned_cnt);
        end
        credit_return = 1'b0;
        if (credit_enable && held > 0) begin
            if (ret_delay == 0) begin
                credit_return = 1'b1;
                held          = held - 1;
                returned_cnt  = returned_cnt + 1;
                ret_delay     = $random(rx_seed) & 3;
            end else begin
                ret_delay = ret_delay - 1;
            end
        end
    end

    task automatic drive(input logic valid, input cic_pkg::din_t value);
        @(negedge clk_out);
        din_valid = valid;
        din       = value;
        if (valid) begin
            model_step(value);
        end
    endtask

    // all expected samples received and all credits back
    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || held != 0) && n < DRAIN_MAX) begin
            @(posedge clk_out);
            n++;
        end
        if (exp_q.size() != 0 || held != 0) begin
            main_other_errs++;
            $display("outputs did not drain in %0d cycles, %0d samples missing", DRAIN_MAX,
                     exp_q.size());
        end
    endtask

    // no output for a while and nothing held by the receiver
    task automatic wait_quiet();
        int n;
        n = 0;
        while (!((cyc - last_rx_cyc) >= QUIET_CYC && held == 0) && n < DRAIN_MAX) begin
            @(posedge clk_out);
            n++;
        end
        if (!((cyc - last_rx_cyc) >= QUIET_CYC && held == 0)) begin
            main_other_errs++;
            $display("output kept running %0d cycles after credits resumed", DRAIN_MAX);
        end
    endtask

    // constant input, settled output is level times DC gain
    task automatic run_dc(input cic_pkg::din_t level);
        cic_pkg::acc_t want;
        want = cic_pkg::acc_t'(longint'(level) * dc_gain());
        repeat (DC_LEN) drive(1'b1, level);
        drive(1'b0, '0);
        wait_drain();
        if (last_out !== want) begin
            main_val_errs++;
            $display("ERR dout: expected 0x%h actual 0x%h for DC input 0x%h", want, last_out,
                     level);
        end
    endtask

    initial begin
        int            density;
        int            vstart;
        int            cnt0;
        int            skipped;
        longint        sum0;
        cic_pkg::din_t x;
        din       = '0;
        din_valid = 1'b0;
        rst_n     = 1'b0;
        density   = 4;
        skipped   = 0;
        rx_seed   = $random(seed);
        model_clear();
        repeat (2) @(negedge clk_out);
        rst_n = 1'b1;

        // idle, nothing may come out
        repeat (IDLE_CYC) begin
            drive(1'b0, '0);
            if (dout_valid !== 1'b0 || overrun !== 1'b0) begin
                main_other_errs++;
                $display("dout_valid or overrun high at %0t with no input", $time);
            end
        end

        // impulse at the start of a group
        cnt0 = out_cnt;
        sum0 = out_sum;
        for (int k = 0; k < IMP_LEN; k++) begin
            drive(1'b1, (k == 0) ? cic_pkg::din_t'(1) : cic_pkg::din_t'(0));
        end
        drive(1'b0, '0);
        wait_drain();
        // each of the R output phases carries 1/R of the gain
        if ((out_sum - sum0) * R != dc_gain()) begin
            main_val_errs++;
            $display("ERR impulse tap sum x R: expected 0x%h actual 0x%h", dc_gain(),
                     (out_sum - sum0) * R);
        end
        if (out_cnt - cnt0 != IMP_LEN / R) begin
            main_val_errs++;
            $display("ERR impulse output count: expected 0x%h actual 0x%h", IMP_LEN / R,
                     out_cnt - cnt0);
        end

        // DC, mid level then full negative scale
        run_dc(cic_pkg::din_t'(1000));
        run_dc(cic_pkg::din_t'(1 << (`CIC_DIN_WIDTH - 1)));

        // random data, density redrawn every 100 cycles
        vstart = m_vcount;
        cnt0   = out_cnt;
        for (int k = 0; k < RAND_CYC; k++) begin
            if (k % 100 == 0) begin
                density = ($random(seed) & 3) + 1;
            end
            x = cic_pkg::din_t'($random(seed));
            drive((($random(seed) & 3) < density), x);
        end
        drive(1'b0, '0);
        wait_drain();
        if (out_cnt - cnt0 != m_vcount / R - vstart / R) begin
            main_val_errs++;
            $display("ERR random output count: expected 0x%h actual 0x%h",
                     m_vcount / R - vstart / R, out_cnt - cnt0);
        end
        @(negedge clk_out);
        if (overrun !== 1'b0) begin
            main_other_errs++;
            $display("overrun set during random traffic with prompt credits");
        end

        // stall, credits withheld until the buffer overflows
        @(posedge clk_out);
        credit_enable = 1'b0;
        skip_mode     = 1'b1;
        cnt0          = out_cnt;
        repeat (STALL_LEN) drive(1'b1, cic_pkg::din_t'($random(seed)));
        drive(1'b0, '0);
        if (overrun !== 1'b1) begin
            main_other_errs++;
            $display("overrun still low after the stall overflowed the buffer");
        end
        @(posedge clk_out);
        credit_enable = 1'b1;
        wait_quiet();
        // whatever is left was dropped at the full buffer
        skipped = mon_skipped + exp_q.size();
        exp_q.delete();
        if (out_cnt - cnt0 < BUF_DEPTH + CREDITS) begin
            main_other_errs++;
            $display("only %0d samples came out of the stall, buffer not fully used",
                     out_cnt - cnt0);
        end
        if (skipped == 0) begin
            main_other_errs++;
            $display("no samples were dropped although the stall overflowed the buffer");
        end
        $display("stall: %0d received, %0d dropped", out_cnt - cnt0, skipped);

        $display("errors: value=%0d other=%0d", mon_val_errs + main_val_errs,
                 mon_other_errs + main_other_errs);
        if (mon_val_errs + main_val_errs + mon_other_errs + main_other_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // run length bound from the phase lengths
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run still going after %0d ns", WATCHDOG_NS);
        $display("errors: value=%0d other=%0d", mon_val_errs + main_val_errs,
                 mon_other_errs + main_other_errs + 1);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== rtl/cic_decimator_top.sv ====
`timescale 1ns/1ps

module cic_decimator_top (
    input  logic          clk_out,
    input  logic          rst_n,
    input  cic_pkg::din_t din,
    input  logic          din_valid,
    output cic_pkg::acc_t dout,
    output logic          dout_valid,
    input  logic          credit_return,
    output logic          overrun
);

    // integrator output at the input rate
    cic_pkg::acc_t integ_out;
    logic          integ_valid;

    // comb output at the decimated rate
    cic_pkg::acc_t comb_out;
    logic          comb_valid;

    // running sums, STAGES cycles of latency
    cic_integrator_chain u_integ (
        .clk_out     (clk_out),
        .rst_n       (rst_n),
        .din         (din),
        .din_valid   (din_valid),
        .integ_out   (integ_out),
        .integ_valid (integ_valid)
    );

    // keep 1 in R, then differentiate
    cic_comb_decimator u_comb (
        .clk_out     (clk_out),
        .rst_n       (rst_n),
        .integ_out   (integ_out),
        .integ_valid (integ_valid),
        .comb_out    (comb_out),
        .comb_valid  (comb_valid)
    );

    // output queue under receiver credits
    cic_credit_buffer u_buf (
        .clk_out       (clk_out),
        .rst_n         (rst_n),
        .comb_out      (comb_out),
        .comb_valid    (comb_valid),
        .dout          (dout),
        .dout_valid    (dout_valid),
        .credit_return (credit_return),
        .overrun       (overrun)
    );

endmodule

// ==== rtl/cic_credit_buffer.sv ====
`timescale 1ns/1ps
`include "cic_settings.svh"

module cic_credit_buffer (
    input  logic          clk_out,
    input  logic          rst_n,
    input  cic_pkg::acc_t comb_out,
    input  logic          comb_valid,
    output cic_pkg::acc_t dout,
    output logic          dout_valid,
    input  logic          credit_return,
    output logic          overrun
);

    localparam int DEPTH   = `CIC_BUF_DEPTH;
    localparam int CREDITS = `CIC_CREDITS;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CRD_W   = $clog2(CREDITS + 1);

    // sample storage
    cic_pkg::acc_t    mem [DEPTH];

    // extra top bit tells full from empty
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;

    // credits still held for the receiver
    logic [CRD_W-1:0] credits;

    logic             empty;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // incoming sample is lost when full
    assign wr_en = comb_valid && !full;

    // empty buffer may still forward the sample arriving now
    assign rd_en = (credits != '0) && (!empty || wr_en);

    always_ff @(posedge clk_out) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            credits    <= CRD_W'(CREDITS);
            dout_valid <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            dout_valid <= rd_en;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky until reset
            if (comb_valid && full) begin
                overrun <= 1'b1;
            end
            // send and return together cancel out
            case ({rd_en, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    if (credits != CRD_W'(CREDITS)) begin
                        credits <= credits + 1'b1;
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

    // storage and output data path
    always_ff @(posedge clk_out) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= comb_out;
        end
        if (rd_en) begin
            // bypass straight from the input when nothing is queued
            dout <= empty ? comb_out : mem[rd_ptr[PTR_W-1:0]];
        end
    end

    // a return with every credit already home would lift the count past CREDITS
    a_credit_bound: assert property (
        @(posedge clk_out) disable iff (!rst_n)
        (credit_return && !rd_en) |-> (credits != CRD_W'(CREDITS))
    );

    // a read from an empty buffer would push the fill level past DEPTH
    a_no_underflow: assert property (
        @(posedge clk_out) disable iff (!rst_n)
        (wr_ptr - rd_ptr) <= (PTR_W + 1)'(DEPTH)
    );

endmodule

// ==== rtl/cic_comb_decimator.sv ====
`timescale 1ns/1ps
`include "cic_settings.svh"

module cic_comb_decimator (
    input  logic          clk_out,
    input  logic          rst_n,
    input  cic_pkg::acc_t integ_out,
    input  logic          integ_valid,
    output cic_pkg::acc_t comb_out,
    output logic          comb_valid
);

    localparam int STAGES = `CIC_STAGES;
    localparam int R      = `CIC_DECIMATION;
    localparam int D      = `CIC_DIFF_DELAY;
    // keep at least one bit when R is 1
    localparam int CNT_W  = (R > 1) ? $clog2(R) : 1;

    // position inside the current group of R
    logic [CNT_W-1:0] dec_cnt;
    // high on the valid that closes a group
    logic             keep;

    // low-rate sample and its strobe
    cic_pkg::acc_t    ds_sample;
    logic             ds_valid;

    // per comb stage input, output and delay line
    cic_pkg::acc_t    stage_in  [STAGES];
    logic             stage_vin [STAGES];
    cic_pkg::acc_t    comb_q    [STAGES];
    logic             comb_v    [STAGES];
    cic_pkg::acc_t    dly_q     [STAGES][D];

    assign keep = integ_valid && (dec_cnt == CNT_W'(R - 1));

    // group counter only moves on input-rate valids
    always_ff @(posedge clk_out) begin
        if (!rst_n) begin
            dec_cnt  <= '0;
            ds_valid <= 1'b0;
        end else begin
            ds_valid <= keep;
            if (keep) begin
                dec_cnt <= '0;
            end else if (integ_valid) begin
                dec_cnt <= dec_cnt + 1'b1;
            end
        end
    end

    // sample register, only read under ds_valid
    always_ff @(posedge clk_out) begin
        if (keep) begin
            ds_sample <= integ_out;
        end
    end

    genvar k;
    generate
        for (k = 0; k < STAGES; k++) begin : g_comb
            if (k == 0) begin : g_head
                assign stage_in[k]  = ds_sample;
                assign stage_vin[k] = ds_valid;
            end else begin : g_tail
                assign stage_in[k]  = comb_q[k-1];
                assign stage_vin[k] = comb_v[k-1];
            end

            always_ff @(posedge clk_out) begin
                if (!rst_n) begin
                    comb_q[k] <= '0;
                    comb_v[k] <= 1'b0;
                    for (int j = 0; j < D; j++) begin
                        dly_q[k][j] <= '0;
                    end
                end else begin
                    comb_v[k] <= stage_vin[k];
                    if (stage_vin[k]) begin
                        // y[n] = x[n] - x[n-D], wrapping
                        comb_q[k]   <= stage_in[k] - dly_q[k][D-1];
                        dly_q[k][0] <= stage_in[k];
                        // older entries move one slot back
                        for (int j = 1; j < D; j++) begin
                            dly_q[k][j] <= dly_q[k][j-1];
                        end
                    end
                end
            end
        end

        // kept samples are at least R cycles apart
        if (R > 1) begin : g_rate_chk
            a_comb_low_rate: assert property (
                @(posedge clk_out) disable iff (!rst_n)
                comb_valid |=> !comb_valid
            );
        end
    endgenerate

    assign comb_out   = comb_q[STAGES-1];
    assign comb_valid = comb_v[STAGES-1];

endmodule

// ==== rtl/cic_integrator_chain.sv ====
`timescale 1ns/1ps
`include "cic_settings.svh"

module cic_integrator_chain (
    input  logic          clk_out,
    input  logic          rst_n,
    input  cic_pkg::din_t din,
    input  logic          din_valid,
    output cic_pkg::acc_t integ_out,
    output logic          integ_valid
);

    localparam int STAGES = `CIC_STAGES;

    // input widened to accumulator width
    cic_pkg::acc_t din_ext;

    // one register per stage
    cic_pkg::acc_t acc_q [STAGES];
    // valid travels next to the data
    logic          vld_q [STAGES];

    // what each stage adds in, and when
    cic_pkg::acc_t stage_in  [STAGES];
    logic          stage_vin [STAGES];

    // signed source so the cast sign-extends
    assign din_ext = cic_pkg::acc_t'(din);

    genvar k;
    generate
        for (k = 0; k < STAGES; k++) begin : g_stage
            if (k == 0) begin : g_head
                // first stage takes the input sample
                assign stage_in[k]  = din_ext;
                assign stage_vin[k] = din_valid;
            end else begin : g_tail
                // later stages take the previous registered sum
                assign stage_in[k]  = acc_q[k-1];
                assign stage_vin[k] = vld_q[k-1];
            end

            always_ff @(posedge clk_out) begin
                if (!rst_n) begin
                    acc_q[k] <= '0;
                    vld_q[k] <= 1'b0;
                end else begin
                    vld_q[k] <= stage_vin[k];
                    // hold between samples, wrap on overflow
                    if (stage_vin[k]) begin
                        acc_q[k] <= acc_q[k] + stage_in[k];
                    end
                end
            end
        end
    endgenerate

    // last stage feeds the decimator
    assign integ_out   = acc_q[STAGES-1];
    assign integ_valid = vld_q[STAGES-1];

    // an X on the strobe would poison every accumulator downstream
    a_din_valid_known: assert property (
        @(posedge clk_out) disable iff (!rst_n)
        !$isunknown(din_valid)
    );

endmodule

// ==== rtl/cic_pkg.sv ====
`include "cic_settings.svh"

package cic_pkg;

    // raw input sample from the source
    // signed two's complement
    typedef logic signed [`CIC_DIN_WIDTH-1:0] din_t;

    // full-precision sample after bit growth
    // used by integrators, combs, buffer and output
    // all arithmetic on it wraps modulo 2**width
    typedef logic signed [`CIC_DOUT_WIDTH-1:0] acc_t;

endpackage

// ==== rtl/cic_settings.svh ====
`ifndef CIC_SETTINGS_SVH
`define CIC_SETTINGS_SVH

// input sample width in bits
`define CIC_DIN_WIDTH 16

// integrator count, equal to comb count
`define CIC_STAGES 3

// decimation factor R, power of two only
`define CIC_DECIMATION 8

// comb differential delay D, 1 or 2
`define CIC_DIFF_DELAY 2

// bit growth is stages * log2(R*D) on top of the input width
`define CIC_DOUT_WIDTH (`CIC_DIN_WIDTH + `CIC_STAGES * $clog2(`CIC_DECIMATION * `CIC_DIFF_DELAY))

// receiver depth and the credits held at reset
`define CIC_CREDITS 4

// output buffer entries
`define CIC_BUF_DEPTH 8

`endif
